//--- filelist.f
src/organ_pkg.sv
src/panel_pkg.sv
src/tone_select.sv
src/tone_divider.sv
src/key_rate_limiter.sv
src/speed_register.sv
src/hex_display.sv
src/organ_top.sv
test/organ_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the organ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module organ_tb -f filelist.f -o organ_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/organ_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '** PASS **' sim.log; then
  exit 0
fi
exit 1

//--- test/organ_tb.sv
module organ_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICK_DIV        = 4;
  localparam int UPDOWN_TICKS    = 3;
  localparam int REFRESH_DIV     = 64;
  localparam int WINDOW          = TICK_DIV * (UPDOWN_TICKS + 1);
  localparam int STEP            = 100;
  localparam int DEFAULT_COUNT   = 12499;
  localparam int TOGGLE_TIMEOUT  = 100_000;
  localparam int DISPLAY_TIMEOUT = 4 * REFRESH_DIV;
  // Last pulse, then two refreshes
  localparam int SETTLE          = 2 * (REFRESH_DIV + 1) + 8;
  localparam logic [7:0] HIGH_LEVEL = 8'h7F;
  localparam logic [7:0] LOW_LEVEL  = 8'h80;

  logic        CLK_50M;
  logic        rst_n;
  logic [3:0]  sw;
  logic [2:0]  key;
  logic [7:0]  audio_sample;
  logic [6:0]  hex_bus [8];
  logic [31:0] rng_state = 32'd61;
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  organ_top #(
    .TICK_DIV     (TICK_DIV),
    .UPDOWN_TICKS (UPDOWN_TICKS),
    .REFRESH_DIV  (REFRESH_DIV)
  ) dut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .key          (key),
    .audio_sample (audio_sample),
    .hex0         (hex_bus[0]),
    .hex1         (hex_bus[1]),
    .hex2         (hex_bus[2]),
    .hex3         (hex_bus[3]),
    .hex4         (hex_bus[4]),
    .hex5         (hex_bus[5]),
    .hex6         (hex_bus[6]),
    .hex7         (hex_bus[7])
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // do re mi fa sol la si do at 50 MHz
  function automatic int note_half_period(input int idx);
    case (idx)
      0: return 47801;
      1: return 42589;
      2: return 37936;
      3: return 35816;
      4: return 31928;
      5: return 28409;
      6: return 25329;
      default: return 23900;
    endcase
  endfunction

  // Lit segments in g..a order, the outputs are the inverse
  function automatic logic [6:0] seg_pattern(input logic [3:0] d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'hA: lit = 7'b1110111;
      4'hB: lit = 7'b1111100;
      4'hC: lit = 7'b0111001;
      4'hD: lit = 7'b1011110;
      4'hE: lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit;
  endfunction

  function automatic logic [31:0] expected_count(input int offset);
    logic [15:0] count;
    count = 16'(DEFAULT_COUNT + offset);
    return {16'h0000, count};
  endfunction

  // ==========================================================================
  // Checks and waits
  // ==========================================================================

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(posedge CLK_50M);
  endtask

  // Counts falling edges until audio_sample changes
  task automatic wait_toggle(input int limit, output int cycles, output logic [7:0] value);
    logic [7:0] start;
    start = audio_sample;
    value = start;
    cycles = 0;
    while (value == start)
    begin
      if (cycles >= limit)
        abort_timeout("a toggle of audio_sample");
      @(negedge CLK_50M);
      cycles++;
      value = audio_sample;
    end
  endtask

  task automatic read_display(output logic [31:0] value);
    logic found;
    value = '0;
    for (int i = 0; i < 8; i++)
    begin
      found = 1'b0;
      for (int d = 0; d < 16; d++)
      begin
        if (!found && seg_pattern(4'(d)) == hex_bus[i])
        begin
          value[i*4 +: 4] = 4'(d);
          found = 1'b1;
        end
      end
      if (!found)
      begin
        errors++;
        $display("Display digit %0d shows a pattern that is no hex digit", i);
      end
    end
  endtask

  task automatic wait_display(input logic [31:0] old_value, output logic [31:0] value);
    int cycles;
    cycles = 0;
    read_display(value);
    while (value == old_value)
    begin
      if (cycles >= DISPLAY_TIMEOUT)
        abort_timeout("a display refresh");
      @(negedge CLK_50M);
      cycles++;
      read_display(value);
    end
  endtask

  task automatic hold_key(input int idx, input int windows);
    @(posedge CLK_50M);
    key[idx] <= 1'b0;
    idle_cycles(windows * WINDOW);
    key[idx] <= 1'b1;
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin
    int          order [8];
    int          j;
    int          tmp;
    int          cycles;
    int          hp;
    int          windows;
    int          diff;
    logic [7:0]  prev_level;
    logic [7:0]  level;
    logic [31:0] prev_disp;
    logic [31:0] disp;

    rst_n <= 1'b0;
    sw    <= 4'h0;
    key   <= 3'b111;
    idle_cycles(4);
    rst_n <= 1'b1;

    start_test();
    @(negedge CLK_50M);
    check("reset_sample", LOW_LEVEL, audio_sample);
    wait_display(32'h0, disp);
    check("reset_display", expected_count(0), disp);
    finish_test("reset");

    // Notes in shuffled order
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)
    begin
      j = int'(next_random() % (i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end

    start_test();
    for (int i = 0; i < 8; i++)
    begin
      hp = note_half_period(order[i]);
      @(posedge CLK_50M);
      sw <= {1'b1, 3'(order[i])};
      // The first toggle may still belong to the previous note
      wait_toggle(TOGGLE_TIMEOUT, cycles, level);
      wait_toggle(TOGGLE_TIMEOUT, cycles, prev_level);
      wait_toggle(TOGGLE_TIMEOUT, cycles, level);
      check($sformatf("note%0d_half_period", order[i]), hp, cycles);
      check($sformatf("note%0d_alternates", order[i]), 1,
            (prev_level == HIGH_LEVEL && level == LOW_LEVEL) ||
            (prev_level == LOW_LEVEL && level == HIGH_LEVEL));
    end
    finish_test("notes");

    start_test();
    @(posedge CLK_50M);
    sw <= {1'b0, 3'(order[7])};
    idle_cycles(5);
    hp = note_half_period(order[7]);
    for (int c = 0; c < 2 * hp; c++)
    begin
      @(negedge CLK_50M);
      if (audio_sample !== LOW_LEVEL)
      begin
        check("tone_off_sample", LOW_LEVEL, audio_sample);
        break;
      end
    end
    finish_test("tone_off");

    start_test();
    read_display(prev_disp);
    windows = 2 + int'(next_random() % 4);
    hold_key(0, windows);
    idle_cycles(SETTLE);
    read_display(disp);
    diff = int'(disp) - int'(prev_disp);
    check("up_positive", 1, diff > 0);
    check("up_step_multiple", 0, diff % STEP);
    check("up_step_bound", 1, diff / STEP <= windows + 1);
    finish_test("speed_up");

    start_test();
    prev_disp = disp;
    // Held longer than key 0, so the offset ends below zero
    windows = windows + 1 + int'(next_random() % 3);
    hold_key(1, windows);
    idle_cycles(SETTLE);
    read_display(disp);
    diff = int'(prev_disp) - int'(disp);
    check("down_positive", 1, diff > 0);
    check("down_step_multiple", 0, diff % STEP);
    @(posedge CLK_50M);
    key[2] <= 1'b0;
    idle_cycles(4);
    key[2] <= 1'b1;
    idle_cycles(SETTLE);
    read_display(disp);
    check("speed_reset_display", expected_count(0), disp);
    finish_test("slow_down_and_reset");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- src/organ_top.sv
module organ_top
  import organ_pkg::*;
  import panel_pkg::*;
#(
  parameter int TICK_DIV     = 50000,
  parameter int UPDOWN_TICKS = 100,
  parameter int REFRESH_DIV  = 25_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [3:0] sw,
  input  logic [2:0] key,
  output sample_t    audio_sample,
  output seg_t       hex0,
  output seg_t       hex1,
  output seg_t       hex2,
  output seg_t       hex3,
  output seg_t       hex4,
  output seg_t       hex5,
  output seg_t       hex6,
  output seg_t       hex7
);

  half_period_t  half_period;
  logic          tone_on;
  logic          up_pulse;
  logic          down_pulse;
  logic          speed_reset;
  sample_count_t sample_count;

  // ==========================================================================
  // Tone path
  // ==========================================================================

  tone_select u_tone_select (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sw          (sw),
    .half_period (half_period),
    .tone_on     (tone_on)
  );

  tone_divider u_tone_divider (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .half_period  (half_period),
    .tone_on      (tone_on),
    .audio_sample (audio_sample)
  );

  // ==========================================================================
  // Speed keys and display
  // ==========================================================================

  key_rate_limiter #(
    .TICK_DIV     (TICK_DIV),
    .UPDOWN_TICKS (UPDOWN_TICKS)
  ) u_key_rate_limiter (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key         (key),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .speed_reset (speed_reset)
  );

  speed_register u_speed_register (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .up_pulse     (up_pulse),
    .down_pulse   (down_pulse),
    .speed_reset  (speed_reset),
    .sample_count (sample_count)
  );

  hex_display #(
    .REFRESH_DIV (REFRESH_DIV)
  ) u_hex_display (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5),
    .hex6         (hex6),
    .hex7         (hex7)
  );

endmodule

//--- src/hex_display.sv
module hex_display
  import panel_pkg::*;
#(
  parameter int REFRESH_DIV = 25_000_000
) (
  input  logic          CLK_50M,
  input  logic          rst_n,
  input  sample_count_t sample_count,
  output seg_t          hex0,
  output seg_t          hex1,
  output seg_t          hex2,
  output seg_t          hex3,
  output seg_t          hex4,
  output seg_t          hex5,
  output seg_t          hex6,
  output seg_t          hex7
);

  localparam int REF_W = $clog2(REFRESH_DIV + 1);

  logic [REF_W-1:0] refresh_cnt;
  logic             refresh;
  display_word_u    disp_q;
  seg_t             segs [8];

  function automatic seg_t hex_to_seg(input logic [3:0] d);
    case (d)
      4'h0: hex_to_seg = 7'b1000000;
      4'h1: hex_to_seg = 7'b1111001;
      4'h2: hex_to_seg = 7'b0100100;
      4'h3: hex_to_seg = 7'b0110000;
      4'h4: hex_to_seg = 7'b0011001;
      4'h5: hex_to_seg = 7'b0010010;
      4'h6: hex_to_seg = 7'b0000010;
      4'h7: hex_to_seg = 7'b1111000;
      4'h8: hex_to_seg = 7'b0000000;
      4'h9: hex_to_seg = 7'b0010000;
      4'hA: hex_to_seg = 7'b0001000;
      4'hB: hex_to_seg = 7'b0000011;
      4'hC: hex_to_seg = 7'b1000110;
      4'hD: hex_to_seg = 7'b0100001;
      4'hE: hex_to_seg = 7'b0000110;
      default: hex_to_seg = 7'b0001110;
    endcase
  endfunction

  // Slow refresh keeps the digits readable
  assign refresh = (refresh_cnt == REF_W'(REFRESH_DIV - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      disp_q      <= '0;
    end
    else
    begin
      refresh_cnt <= refresh ? '0 : refresh_cnt + 1'b1;
      if (refresh)
        disp_q.word <= {16'h0000, sample_count};
    end
  end

  for (genvar i = 0; i < 8; i++)
  begin : g_digit
    assign segs[i] = hex_to_seg(disp_q.digit[i]);
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];
  assign hex6 = segs[6];
  assign hex7 = segs[7];

endmodule

//--- src/speed_register.sv
module speed_register
  import panel_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          rst_n,
  input  logic          up_pulse,
  input  logic          down_pulse,
  input  logic          speed_reset,
  output sample_count_t sample_count
);

  speed_t offset;

  // Reset key wins over both pulses
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || speed_reset)
      offset <= '0;
    else if (up_pulse && !down_pulse)
      offset <= offset + SPEED_STEP;
    else if (down_pulse && !up_pulse)
      offset <= offset - SPEED_STEP;
  end

  // Two's complement add, wraps like the hardware counter
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_count <= DEFAULT_SAMPLE_COUNT;
    else
      sample_count <= DEFAULT_SAMPLE_COUNT + sample_count_t'(offset);
  end

  a_both_pulses: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (up_pulse && down_pulse && !speed_reset) |=> (offset == $past(offset)))
    else $error("simultaneous pulses moved the offset");

endmodule

//--- src/key_rate_limiter.sv
module key_rate_limiter #(
  parameter int TICK_DIV     = 50000,
  parameter int UPDOWN_TICKS = 100
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [2:0] key,
  output logic       up_pulse,
  output logic       down_pulse,
  output logic       speed_reset
);

  localparam int TICK_W = $clog2(TICK_DIV + 1);
  localparam int WIN_W  = $clog2(UPDOWN_TICKS + 2);

  logic [2:0]        key_sync1;
  logic [2:0]        key_sync2;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  logic [WIN_W-1:0]  win_cnt;
  logic              win_end;

  // ==========================================================================
  // Key synchronizers, keys are active low
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_sync1 <= '0;
      key_sync2 <= '0;
    end
    else
    begin
      key_sync1 <= ~key;
      key_sync2 <= key_sync1;
    end
  end

  assign speed_reset = key_sync2[2];

  // ==========================================================================
  // 1 kHz tick and rate window
  // ==========================================================================

  assign tick    = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign win_end = tick && (win_cnt == WIN_W'(UPDOWN_TICKS));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      win_cnt  <= '0;
    end
    else
    begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (win_end)
        win_cnt <= '0;
      else if (tick)
        win_cnt <= win_cnt + 1'b1;
    end
  end

  // One pulse per held key at each window end
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      up_pulse   <= 1'b0;
      down_pulse <= 1'b0;
    end
    else
    begin
      up_pulse   <= win_end && key_sync2[0];
      down_pulse <= win_end && key_sync2[1];
    end
  end

  a_up_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    up_pulse |=> !up_pulse)
    else $error("up_pulse high on consecutive cycles");

endmodule

//--- src/tone_divider.sv
module tone_divider
  import organ_pkg::*;
(
  input  logic         CLK_50M,
  input  logic         rst_n,
  input  half_period_t half_period,
  input  logic         tone_on,
  output sample_t      audio_sample
);

  half_period_t cnt;
  half_period_t hp_q;
  logic         wave;

  // Half period of the previous cycle, to spot a note change
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      hp_q <= '0;
    else
      hp_q <= half_period;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      wave <= 1'b0;
    end
    else if (!tone_on)
    begin
      cnt  <= '0;
      wave <= 1'b0;
    end
    else if (half_period != hp_q)
      cnt <= '0;   // new note, start a fresh half wave
    else if (cnt == half_period_t'(half_period - 1'b1))
    begin
      cnt  <= '0;
      wave <= ~wave;
    end
    else
      cnt <= cnt + 1'b1;
  end

  // Signed sample from the 1-bit wave
  assign audio_sample = wave ? SAMPLE_HIGH : SAMPLE_LOW;

  // Holds once the note has been stable for a cycle
  a_cnt_in_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (half_period == hp_q) |-> (cnt <= half_period))
    else $error("tone_divider counter above half period");

endmodule

//--- src/tone_select.sv
module tone_select
  import organ_pkg::*;
(
  input  logic         CLK_50M,
  input  logic         rst_n,
  input  logic [3:0]   sw,
  output half_period_t half_period,
  output logic         tone_on
);

  logic [3:0] sw_sync1;
  logic [3:0] sw_sync2;
  note_sel_t  note;

  // Switches are asynchronous to the clock
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sw_sync1 <= '0;
      sw_sync2 <= '0;
    end
    else
    begin
      sw_sync1 <= sw;
      sw_sync2 <= sw_sync1;
    end
  end

  assign note = sw_sync2[2:0];

  // Half period and enable registered together
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      half_period <= NOTE_HALF_PERIOD[0];
      tone_on     <= 1'b0;
    end
    else
    begin
      half_period <= NOTE_HALF_PERIOD[note];
      tone_on     <= sw_sync2[3];
    end
  end

endmodule

//--- src/panel_pkg.sv
package panel_pkg;

  // ==========================================================================
  // Speed control
  // ==========================================================================

  // Signed offset applied to the scope sampling count
  typedef logic signed [15:0] speed_t;

  // One key step
  localparam speed_t SPEED_STEP = 16'sd100;

  // Scope sampling count, 2 kHz by default
  typedef logic [15:0] sample_count_t;

  localparam sample_count_t DEFAULT_SAMPLE_COUNT = 16'd12499;

  // ==========================================================================
  // Seven-segment display
  // ==========================================================================

  // Segments g..a, a segment lights when its bit is 0
  typedef logic [6:0] seg_t;

  // Display latch, written as one word and read back as hex digits
  typedef union packed {
    logic [31:0]      word;
    logic [7:0][3:0]  digit;
  } display_word_u;

endpackage

//--- src/organ_pkg.sv
package organ_pkg;

  // ==========================================================================
  // Note selection and tone timing
  // ==========================================================================

  // Index of a note inside one octave
  typedef logic [2:0] note_sel_t;

  // Clock cycles of CLK_50M per half wave
  typedef logic [15:0] half_period_t;

  // do re mi fa sol la si do, half periods at 50 MHz
  localparam half_period_t NOTE_HALF_PERIOD [8] = '{
    16'd47801,
    16'd42589,
    16'd37936,
    16'd35816,
    16'd31928,
    16'd28409,
    16'd25329,
    16'd23900
  };

  // ==========================================================================
  // Audio samples
  // ==========================================================================

  typedef logic signed [7:0] sample_t;

  // Square wave maps onto the two extremes of the signed range
  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;

endpackage
